// ==== axi_sram_top.f ====
+incdir+.
axi_sram_pkg.sv
axi_sram_wr_ctrl.sv
axi_sram_mem.sv
axi_sram_rd_ctrl.sv
axi_sram_top.sv
axi_sram_tb.sv

// ==== Makefile ====
# Verilator build, run and lint of the AXI4 SRAM slave.

TOOL     := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/100ps -Wno-fatal -j 0
TOP      := axi_sram_tb
RTL_TOP  := axi_sram_top
FILELIST := axi_sram_top.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

lint:
	$(TOOL) --lint-only --timing --timescale 1ns/100ps -Wall --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== axi_sram_tb.sv ====
// ======================================================================
// AXI4 SRAM slave testbench.
// Drives write and read bursts through the AXI4 port, keeps a byte-level
// reference memory and checks responses and channel timing.
// ======================================================================

`default_nettype none

`include "axi_sram_config.svh"

module axi_sram_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MEM_WORDS = 1 << `AXI_SRAM_MEM_ADDR_BITS;
    localparam int LANES     = `AXI_SRAM_DATA_WIDTH / 8;

    // the whole sequence takes a little over 2000 cycles.
    localparam int TIMEOUT_CYCLES = 20000;

    logic                      ACLK;
    logic                      ARESETn;
    logic                      AWVALID;
    logic                      AWREADY;
    axi_sram_pkg::addr_t       AWADDR;
    axi_sram_pkg::id_t         AWID;
    axi_sram_pkg::len_t        AWLEN;
    logic                      WVALID;
    logic                      WREADY;
    axi_sram_pkg::data_t       WDATA;
    axi_sram_pkg::strb_t       WSTRB;
    logic                      WLAST;
    logic                      BVALID;
    logic                      BREADY;
    axi_sram_pkg::id_t         BID;
    logic                      ARVALID;
    logic                      ARREADY;
    axi_sram_pkg::addr_t       ARADDR;
    axi_sram_pkg::id_t         ARID;
    axi_sram_pkg::len_t        ARLEN;
    logic                      RVALID;
    logic                      RREADY;
    axi_sram_pkg::data_t       RDATA;
    axi_sram_pkg::id_t         RID;
    logic                      RLAST;

    int                        seed = 32'h6e5f6936;
    int                        cycles = 0;
    int                        writes_done = 0;
    int                        b_count;

    // reference memory with one entry per byte of the array.
    logic [7:0]                ref_bytes [MEM_WORDS*LANES];
    axi_sram_pkg::data_t       beats_q [$];
    axi_sram_pkg::data_t       first_q [$];

    axi_sram_top axi_sram_top_inst (.*);

    initial begin
        ACLK = 1'b0;
        forever #5 ACLK = ~ACLK;
    end

    // ==================================================================
    // failure reporting and reference model
    // ==================================================================

    task automatic stop_on_failure(input string what);
        $display("%s", what);
        $display("Testbench failed");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic report_error(input string msg);
        stop_on_failure($sformatf("** Error at %0t ns: %s", $time, msg));
    endtask

    function automatic axi_sram_pkg::data_t expected_word(input int word);
        axi_sram_pkg::data_t w;
        for (int i = 0; i < LANES; i++) begin
            w[8*i +: 8] = ref_bytes[word*LANES + i];
        end
        return w;
    endfunction

    // only the strobed byte lanes of the word take the new data.
    task automatic model_write(input int word, input axi_sram_pkg::data_t data,
                               input axi_sram_pkg::strb_t strb);
        for (int i = 0; i < LANES; i++) begin
            if (strb[i]) begin
                ref_bytes[word*LANES + i] = data[8*i +: 8];
            end
        end
    endtask

    // ==================================================================
    // AXI master tasks
    // ==================================================================

    task automatic write_burst(input int start, input int len, input axi_sram_pkg::id_t id,
                               input bit rand_strb);
        axi_sram_pkg::data_t data;
        axi_sram_pkg::strb_t strb;
        @(negedge ACLK);
        AWVALID = 1'b1;
        AWADDR  = axi_sram_pkg::addr_t'(start * LANES);
        AWID    = id;
        AWLEN   = axi_sram_pkg::len_t'(len);
        // BREADY stays high over the whole burst and one cycle past its B,
        // so an early or repeated response is counted too.
        BREADY  = 1'b1;
        while (!AWREADY) begin
            @(negedge ACLK);
        end
        @(negedge ACLK);
        AWVALID = 1'b0;
        for (int beat = 0; beat <= len; beat++) begin
            data   = $random(seed);
            strb   = rand_strb ? axi_sram_pkg::strb_t'($random(seed)) : '1;
            WVALID = 1'b1;
            WDATA  = data;
            WSTRB  = strb;
            WLAST  = (beat == len);
            while (!WREADY) begin
                @(negedge ACLK);
            end
            // the beat lands on the word after the last one and wraps at the top.
            model_write((start + beat) % MEM_WORDS, data, strb);
            @(negedge ACLK);
        end
        WVALID = 1'b0;
        WLAST  = 1'b0;
        while (!BVALID) begin
            @(negedge ACLK);
        end
        assert (BID == id) else report_error($sformatf("BID %h, expected %h", BID, id));
        repeat (2) begin
            @(negedge ACLK);
        end
        BREADY = 1'b0;
        writes_done++;
        assert (b_count == writes_done)
            else report_error($sformatf("%0d B responses for %0d bursts", b_count, writes_done));
    endtask

    task automatic read_burst(input int start, input int len, input axi_sram_pkg::id_t id,
                              input bit stall);
        int beat;
        axi_sram_pkg::data_t exp;
        beat = 0;
        beats_q.delete();
        @(negedge ACLK);
        ARVALID = 1'b1;
        ARADDR  = axi_sram_pkg::addr_t'(start * LANES);
        ARID    = id;
        ARLEN   = axi_sram_pkg::len_t'(len);
        while (!ARREADY) begin
            @(negedge ACLK);
        end
        @(negedge ACLK);
        ARVALID = 1'b0;
        while (beat <= len) begin
            RREADY = stall ? (($random(seed) & 1) != 0) : 1'b1;
            if (RVALID && RREADY) begin
                exp = expected_word((start + beat) % MEM_WORDS);
                assert (RDATA == exp)
                    else report_error($sformatf("RDATA %h on beat %0d, expected %h",
                                                RDATA, beat, exp));
                assert (RID == id) else report_error($sformatf("RID %h, expected %h", RID, id));
                assert (RLAST == (beat == len))
                    else report_error($sformatf("RLAST %b on beat %0d of %0d",
                                                RLAST, beat, len + 1));
                beats_q.push_back(RDATA);
                beat++;
            end
            @(negedge ACLK);
        end
        RREADY = 1'b0;
    endtask

    task automatic compare_with_unstalled();
        assert (beats_q.size() == first_q.size())
            else report_error("stalled read returned a different number of beats");
        foreach (beats_q[i]) begin
            assert (beats_q[i] == first_q[i])
                else report_error($sformatf("stalled beat %0d is %h, unstalled was %h",
                                            i, beats_q[i], first_q[i]));
        end
    endtask

    // ==================================================================
    // channel checks
    // ==================================================================

    always @(posedge ACLK) begin
        if (!ARESETn) begin
            b_count <= 0;
        end else if (BVALID && BREADY) begin
            b_count <= b_count + 1;
        end
    end

    r_stall_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
        (RVALID && !RREADY) |=> (RVALID && $stable(RDATA) && $stable(RID) && $stable(RLAST)))
        else report_error("R channel changed while stalled by RREADY");

    // the first beat of a burst shows up two cycles after the AR handshake.
    r_latency_after_ar: assert property (@(posedge ACLK) disable iff (!ARESETn)
        $past(ARVALID && ARREADY, 2) |-> $rose(RVALID))
        else report_error("RVALID did not rise 2 cycles after the AR handshake");

    r_latency_rise: assert property (@(posedge ACLK) disable iff (!ARESETn)
        $rose(RVALID) |-> $past(ARVALID && ARREADY, 2))
        else report_error("RVALID rose without an AR handshake 2 cycles earlier");

    always @(posedge ACLK) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            stop_on_failure($sformatf("Timeout: the test did not end within %0d clock cycles",
                                      TIMEOUT_CYCLES));
        end
    end

    // ==================================================================
    // test sequence
    // ==================================================================

    initial begin
        axi_sram_pkg::id_t id;
        int start;
        int len;
        ARESETn = 1'b0;
        AWVALID = 1'b0;
        AWADDR  = '0;
        AWID    = '0;
        AWLEN   = '0;
        WVALID  = 1'b0;
        WDATA   = '0;
        WSTRB   = '0;
        WLAST   = 1'b0;
        BREADY  = 1'b0;
        ARVALID = 1'b0;
        ARADDR  = '0;
        ARID    = '0;
        ARLEN   = '0;
        RREADY  = 1'b0;
        repeat (2) begin
            @(posedge ACLK);
        end
        @(negedge ACLK);
        ARESETn = 1'b1;
        assert (!BVALID && !RVALID && AWREADY && ARREADY)
            else report_error("channel handshake outputs are wrong after reset");

        // random bursts with full strobes are each read back right away.
        for (int n = 0; n < 8; n++) begin
            start = $random(seed) & (MEM_WORDS - 1);
            len   = $random(seed) & 31;
            id    = axi_sram_pkg::id_t'($random(seed));
            write_burst(start, len, id, 1'b0);
            id    = axi_sram_pkg::id_t'($random(seed));
            read_burst(start, len, id, 1'b0);
        end

        // partial strobes on top of a full-word baseline.
        write_burst(200, 7, 4'h3, 1'b0);
        write_burst(200, 7, 4'h5, 1'b1);
        write_burst(202, 3, 4'h6, 1'b1);
        read_burst(200, 7, 4'h9, 1'b0);

        // long bursts are read once freely and once with RREADY toggling.
        for (int n = 0; n < 2; n++) begin
            start = (n == 0) ? 512 : ($random(seed) & (MEM_WORDS - 1));
            len   = (n == 0) ? 255 : 63;
            write_burst(start, len, 4'hc, 1'b0);
            read_burst(start, len, 4'h1, 1'b0);
            first_q = beats_q;
            read_burst(start, len, 4'h2, 1'b1);
            compare_with_unstalled();
        end

        // bursts that run past word 1023 into word 0.
        write_burst(1020, 9, 4'ha, 1'b0);
        read_burst(1020, 9, 4'hb, 1'b0);
        read_burst(1022, 3, 4'hd, 1'b1);

        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== axi_sram_top.sv ====
// ======================================================================
// AXI4 SRAM slave.
// Splits the AXI4 port between an independent write engine and read
// engine, both of which share one on-chip SRAM array.
// ======================================================================

`default_nettype none

module axi_sram_top (
    input  wire logic                     ACLK,
    input  wire logic                     ARESETn,

    // write address channel.
    input  wire logic                     AWVALID,
    output logic                          AWREADY,
    input  wire axi_sram_pkg::addr_t      AWADDR,
    input  wire axi_sram_pkg::id_t        AWID,
    input  wire axi_sram_pkg::len_t       AWLEN,

    // write data channel.
    input  wire logic                     WVALID,
    output logic                          WREADY,
    input  wire axi_sram_pkg::data_t      WDATA,
    input  wire axi_sram_pkg::strb_t      WSTRB,
    input  wire logic                     WLAST,

    // write response channel.
    output logic                          BVALID,
    input  wire logic                     BREADY,
    output axi_sram_pkg::id_t             BID,

    // read address channel.
    input  wire logic                     ARVALID,
    output logic                          ARREADY,
    input  wire axi_sram_pkg::addr_t      ARADDR,
    input  wire axi_sram_pkg::id_t        ARID,
    input  wire axi_sram_pkg::len_t       ARLEN,

    // read data channel.
    output logic                          RVALID,
    input  wire logic                     RREADY,
    output axi_sram_pkg::data_t           RDATA,
    output axi_sram_pkg::id_t             RID,
    output logic                          RLAST
);

    // array write port, driven by the write engine.
    logic                        wr_en;
    axi_sram_pkg::word_addr_t    wr_addr;
    axi_sram_pkg::data_t         wr_data;
    axi_sram_pkg::strb_t         wr_strb;

    // array read port, driven by the read engine.
    logic                        rd_en;
    axi_sram_pkg::word_addr_t    rd_addr;
    axi_sram_pkg::data_t         rd_data;

    axi_sram_wr_ctrl axi_sram_wr_ctrl_inst (
        .ACLK    (ACLK),
        .ARESETn (ARESETn),
        .AWVALID (AWVALID),
        .AWREADY (AWREADY),
        .AWADDR  (AWADDR),
        .AWID    (AWID),
        .AWLEN   (AWLEN),
        .WVALID  (WVALID),
        .WREADY  (WREADY),
        .WDATA   (WDATA),
        .WSTRB   (WSTRB),
        .WLAST   (WLAST),
        .BVALID  (BVALID),
        .BREADY  (BREADY),
        .BID     (BID),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .wr_strb (wr_strb)
    );

    axi_sram_mem axi_sram_mem_inst (
        .ACLK    (ACLK),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .wr_strb (wr_strb),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    axi_sram_rd_ctrl axi_sram_rd_ctrl_inst (
        .ACLK    (ACLK),
        .ARESETn (ARESETn),
        .ARVALID (ARVALID),
        .ARREADY (ARREADY),
        .ARADDR  (ARADDR),
        .ARID    (ARID),
        .ARLEN   (ARLEN),
        .RVALID  (RVALID),
        .RREADY  (RREADY),
        .RDATA   (RDATA),
        .RID     (RID),
        .RLAST   (RLAST),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

`default_nettype wire

// ==== axi_sram_rd_ctrl.sv ====
// ======================================================================
// AXI4 SRAM read channel engine.
// Accepts one AR burst at a time and streams it out of the array's
// registered read port, one beat per cycle while RREADY is high.
// ======================================================================

`default_nettype none

`include "axi_sram_config.svh"

module axi_sram_rd_ctrl (
    input  wire logic                     ACLK,
    input  wire logic                     ARESETn,

    // read address channel.
    input  wire logic                     ARVALID,
    output logic                          ARREADY,
    input  wire axi_sram_pkg::addr_t      ARADDR,
    input  wire axi_sram_pkg::id_t        ARID,
    input  wire axi_sram_pkg::len_t       ARLEN,

    // read data channel.
    output logic                          RVALID,
    input  wire logic                     RREADY,
    output axi_sram_pkg::data_t           RDATA,
    output axi_sram_pkg::id_t             RID,
    output logic                          RLAST,

    // array read port.
    output logic                          rd_en,
    output axi_sram_pkg::word_addr_t      rd_addr,
    input  wire axi_sram_pkg::data_t      rd_data
);

    axi_sram_pkg::rd_state_e   state_q;
    axi_sram_pkg::rd_state_e   state_d;

    // next word to fetch from the array.
    axi_sram_pkg::word_addr_t  next_q;
    axi_sram_pkg::id_t         id_q;
    axi_sram_pkg::len_t        len_q;

    // index of the beat currently shown on R.
    axi_sram_pkg::len_t        cnt_q;

    logic                      ar_hs;
    logic                      r_hs;

    assign ar_hs = ARVALID && ARREADY;
    assign r_hs  = RVALID && RREADY;

    // ==================================================================
    // channel outputs
    // ==================================================================

    assign ARREADY = (state_q == axi_sram_pkg::rd_idle);
    assign RVALID  = (state_q == axi_sram_pkg::rd_data);
    assign RLAST   = (state_q == axi_sram_pkg::rd_data) && (cnt_q == len_q);
    assign RID     = id_q;

    // the array output register is the R data register. it holds
    // while the beat waits for RREADY.
    assign RDATA   = rd_data;

    // the first word is fetched in rd_fetch. after that a new word is
    // fetched only in the cycle that consumes the shown beat, so the
    // next beat appears on the following cycle.
    assign rd_en   = (state_q == axi_sram_pkg::rd_fetch) || r_hs;
    assign rd_addr = next_q;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            axi_sram_pkg::rd_idle: begin
                if (ar_hs) begin
                    state_d = axi_sram_pkg::rd_fetch;
                end
            end
            axi_sram_pkg::rd_fetch: begin
                state_d = axi_sram_pkg::rd_data;
            end
            axi_sram_pkg::rd_data: begin
                if (r_hs && RLAST) begin
                    state_d = axi_sram_pkg::rd_idle;
                end
            end
            default: begin
                state_d = axi_sram_pkg::rd_idle;
            end
        endcase
    end

    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            state_q <= axi_sram_pkg::rd_idle;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            if (ar_hs) begin
                cnt_q <= '0;
            end else if (r_hs && !RLAST) begin
                cnt_q <= cnt_q + 8'd1;
            end
        end
    end

    // ==================================================================
    // burst attributes and fetch pointer
    // ==================================================================

    always_ff @(posedge ACLK) begin
        if (ar_hs) begin
            next_q <= ARADDR[`AXI_SRAM_MEM_ADDR_BITS+1:2];
            id_q   <= ARID;
            len_q  <= ARLEN;
        end else if (rd_en) begin
            // wraps from the last word back to word 0.
            next_q <= next_q + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== axi_sram_mem.sv ====
// ======================================================================
// AXI4 SRAM storage array.
// One word-wide write port with byte enables and one registered read
// port whose output holds while no read is issued.
// ======================================================================

`default_nettype none

`include "axi_sram_config.svh"

module axi_sram_mem (
    input  wire logic                       ACLK,

    // write port, byte lanes enabled by wr_strb.
    input  wire logic                       wr_en,
    input  wire axi_sram_pkg::word_addr_t   wr_addr,
    input  wire axi_sram_pkg::data_t        wr_data,
    input  wire axi_sram_pkg::strb_t        wr_strb,

    // read port, one cycle of latency.
    input  wire logic                       rd_en,
    input  wire axi_sram_pkg::word_addr_t   rd_addr,
    output axi_sram_pkg::data_t             rd_data
);

    localparam int unsigned DEPTH = 1 << `AXI_SRAM_MEM_ADDR_BITS;
    localparam int unsigned LANES = $bits(axi_sram_pkg::strb_t);

    axi_sram_pkg::data_t  mem [DEPTH];

    // ==================================================================
    // byte-enabled write
    // ==================================================================

    always_ff @(posedge ACLK) begin
        if (wr_en) begin
            for (int unsigned i = 0; i < LANES; i++) begin
                if (wr_strb[i]) begin
                    mem[wr_addr][8*i +: 8] <= wr_data[8*i +: 8];
                end
            end
        end
    end

    // ==================================================================
    // registered read
    // ==================================================================

    // a read of a word being written on the same edge returns the old
    // contents. the output only moves when a read is issued, which lets
    // the read engine stall a beat by holding rd_en low.
    always_ff @(posedge ACLK) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

// ==== axi_sram_wr_ctrl.sv ====
// ======================================================================
// AXI4 SRAM write channel engine.
// Accepts one AW burst at a time, writes each W beat into the array
// with its byte strobes, and answers with a single B response.
// ======================================================================

`default_nettype none

`include "axi_sram_config.svh"

module axi_sram_wr_ctrl (
    input  wire logic                     ACLK,
    input  wire logic                     ARESETn,

    // write address channel.
    input  wire logic                     AWVALID,
    output logic                          AWREADY,
    input  wire axi_sram_pkg::addr_t      AWADDR,
    input  wire axi_sram_pkg::id_t        AWID,
    input  wire axi_sram_pkg::len_t       AWLEN,

    // write data channel.
    input  wire logic                     WVALID,
    output logic                          WREADY,
    input  wire axi_sram_pkg::data_t      WDATA,
    input  wire axi_sram_pkg::strb_t      WSTRB,
    input  wire logic                     WLAST,

    // write response channel.
    output logic                          BVALID,
    input  wire logic                     BREADY,
    output axi_sram_pkg::id_t             BID,

    // array write port.
    output logic                          wr_en,
    output axi_sram_pkg::word_addr_t      wr_addr,
    output axi_sram_pkg::data_t           wr_data,
    output axi_sram_pkg::strb_t           wr_strb
);

    axi_sram_pkg::wr_state_e   state_q;
    axi_sram_pkg::wr_state_e   state_d;

    axi_sram_pkg::word_addr_t  start_q;
    axi_sram_pkg::id_t         id_q;
    axi_sram_pkg::len_t        len_q;
    axi_sram_pkg::len_t        left_q;

    logic                      aw_hs;
    logic                      w_hs;
    logic                      b_hs;

    assign aw_hs = AWVALID && AWREADY;
    assign w_hs  = WVALID && WREADY;
    assign b_hs  = BVALID && BREADY;

    // ==================================================================
    // channel handshake outputs, decoded from the state
    // ==================================================================

    assign AWREADY = (state_q == axi_sram_pkg::wr_idle);
    assign WREADY  = (state_q == axi_sram_pkg::wr_data);
    assign BVALID  = (state_q == axi_sram_pkg::wr_resp);
    assign BID     = id_q;

    // an accepted beat goes straight to the array on the same edge.
    // the offset into the burst is the announced length minus the
    // beats still expected, so the first beat lands on the AW word.
    assign wr_en   = w_hs;
    assign wr_addr = start_q + axi_sram_pkg::word_addr_t'(len_q - left_q);
    assign wr_data = WDATA;
    assign wr_strb = WSTRB;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            axi_sram_pkg::wr_idle: begin
                if (aw_hs) begin
                    state_d = axi_sram_pkg::wr_data;
                end
            end
            axi_sram_pkg::wr_data: begin
                // WLAST alone closes the burst.
                if (w_hs && WLAST) begin
                    state_d = axi_sram_pkg::wr_resp;
                end
            end
            axi_sram_pkg::wr_resp: begin
                if (b_hs) begin
                    state_d = axi_sram_pkg::wr_idle;
                end
            end
            default: begin
                state_d = axi_sram_pkg::wr_idle;
            end
        endcase
    end

    always_ff @(posedge ACLK) begin
        if (!ARESETn) begin
            state_q <= axi_sram_pkg::wr_idle;
            left_q  <= '0;
        end else begin
            state_q <= state_d;
            if (aw_hs) begin
                left_q <= AWLEN;
            end else if (w_hs && !WLAST) begin
                left_q <= left_q - 8'd1;
            end
        end
    end

    // burst attributes captured at the AW handshake.
    always_ff @(posedge ACLK) begin
        if (aw_hs) begin
            start_q <= AWADDR[`AXI_SRAM_MEM_ADDR_BITS+1:2];
            id_q    <= AWID;
            len_q   <= AWLEN;
        end
    end

endmodule

`default_nettype wire

// ==== axi_sram_pkg.sv ====
// ======================================================================
// AXI4 SRAM slave types.
// Width typedefs and the state encodings of the two channel engines.
// ======================================================================

`default_nettype none

`include "axi_sram_config.svh"

package axi_sram_pkg;

    typedef logic [`AXI_SRAM_ADDR_WIDTH-1:0]     addr_t;
    typedef logic [`AXI_SRAM_DATA_WIDTH-1:0]     data_t;
    typedef logic [`AXI_SRAM_DATA_WIDTH/8-1:0]   strb_t;
    typedef logic [`AXI_SRAM_ID_WIDTH-1:0]       id_t;

    // AXI4 burst length field, beats minus one.
    typedef logic [7:0]                          len_t;

    // index into the array; it wraps at the top of memory by itself.
    typedef logic [`AXI_SRAM_MEM_ADDR_BITS-1:0]  word_addr_t;

    // write channel engine.
    typedef enum logic [1:0] {wr_idle, wr_data, wr_resp} wr_state_e;

    // read channel engine.
    typedef enum logic [1:0] {rd_idle, rd_fetch, rd_data} rd_state_e;

endpackage

`default_nettype wire

// ==== axi_sram_config.svh ====
// ======================================================================
// AXI4 SRAM slave configuration.
// Bus widths and the depth of the on-chip array shared by the write
// engine, the read engine and the memory.
// ======================================================================

`ifndef AXI_SRAM_CONFIG_SVH
`define AXI_SRAM_CONFIG_SVH

// byte address carried on AWADDR and ARADDR.
`define AXI_SRAM_ADDR_WIDTH 32

// one data beat; every beat is a full word.
`define AXI_SRAM_DATA_WIDTH 32

// width of AWID, BID, ARID and RID.
`define AXI_SRAM_ID_WIDTH 4

// word-address bits of the array, 1024 words.
// the word index is taken from byte-address bits [MEM_ADDR_BITS+1:2].
`define AXI_SRAM_MEM_ADDR_BITS 10

`endif
